// File: verilog/gpu_cfg.svh
`ifndef GPU_CFG_SVH
`define GPU_CFG_SVH

// Threads per warp and lanes carried by one commit packet
`define GPU_NUM_THREADS 4
`define GPU_NUM_LANES 2

// Warp count and the number of issue slots the warps are spread over
`define GPU_NUM_WARPS 8
`define GPU_ISSUE_CNT 4

// Execution-unit ports feeding the commit stage
`define GPU_BLOCK_SIZE 2

// Datapath and register index widths
`define GPU_XLEN 32
`define GPU_NR_BITS 5
`define GPU_UUID_WIDTH 8

// Derived widths, kept in step with the sizes above by hand
// WID is log2(warps), PID is log2(threads / lanes)
`define GPU_WID_BITS 3
`define GPU_PID_BITS 1

// Slot index width is log2(issue slots), block index width is log2(ports)
`define GPU_SLOT_BITS 2
`define GPU_BLOCK_BITS 1

`endif

// File: verilog/gpu_pkg.sv
`default_nettype none

`include "gpu_cfg.svh"

package gpu_pkg;

    // Commit packet as it leaves an execution unit, covering one lane slice
    typedef struct packed {
        logic [`GPU_UUID_WIDTH-1:0]                    uuid;
        logic [`GPU_WID_BITS-1:0]                      wid;
        logic [`GPU_NUM_LANES-1:0]                     tmask;
        logic [`GPU_XLEN-1:0]                          pc;
        logic                                          wb;
        logic [`GPU_NR_BITS-1:0]                       rd;
        logic [`GPU_NUM_LANES-1:0][`GPU_XLEN-1:0]      data;
        logic [`GPU_PID_BITS-1:0]                      pid;
        logic                                          sop;
        logic                                          eop;
        logic                                          halt;
    } commit_lane_t;

    // Same packet after the lane slice has been placed at its thread positions
    typedef struct packed {
        logic [`GPU_UUID_WIDTH-1:0]                    uuid;
        logic [`GPU_WID_BITS-1:0]                      wid;
        logic [`GPU_NUM_THREADS-1:0]                   tmask;
        logic [`GPU_XLEN-1:0]                          pc;
        logic                                          wb;
        logic [`GPU_NR_BITS-1:0]                       rd;
        logic [`GPU_NUM_THREADS-1:0][`GPU_XLEN-1:0]    data;
        logic                                          sop;
        logic                                          eop;
        logic                                          halt;
    } commit_full_t;

    // One record per retired instruction
    // tmask is the union of the masks of every packet from sop to eop
    typedef struct packed {
        logic [`GPU_UUID_WIDTH-1:0]                    uuid;
        logic [`GPU_WID_BITS-1:0]                      wid;
        logic [`GPU_XLEN-1:0]                          pc;
        logic                                          halt;
        logic [`GPU_NUM_THREADS-1:0]                   tmask;
    } retire_t;

endpackage

`default_nettype wire

// File: verilog/elastic_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module elastic_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             valid_in,
    input  logic [DATAW-1:0] data_in,
    output logic             ready_in,

    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  logic             ready_out
);

    logic             out_valid_r;
    logic [DATAW-1:0] out_data_r;
    logic             skid_valid_r;
    logic [DATAW-1:0] skid_data_r;

    logic push;
    logic out_free;

    // Input side only sees the skid register, so ready is a flop output
    assign ready_in = !skid_valid_r;
    assign push     = valid_in && ready_in;

    // The output register can take a new entry when empty or being drained
    assign out_free = !out_valid_r || ready_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_r  <= 1'b0;
            skid_valid_r <= 1'b0;
        end else if (out_free) begin
            out_valid_r  <= skid_valid_r || push;
            skid_valid_r <= 1'b0;
        end else if (push) begin
            // Output is stalled, park the incoming entry
            skid_valid_r <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data_r <= skid_valid_r ? skid_data_r : data_in;
        end
        if (push && !out_free) begin
            skid_data_r <= data_in;
        end
    end

    assign valid_out = out_valid_r;
    assign data_out  = out_data_r;

endmodule

`default_nettype wire

// File: verilog/commit_gather.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_cfg.svh"

module commit_gather (
    input  logic                                            clk,
    input  logic                                            rst,

    input  logic [`GPU_BLOCK_SIZE-1:0]                      in_valid,
    input  gpu_pkg::commit_lane_t [`GPU_BLOCK_SIZE-1:0]     in_data,
    output logic [`GPU_BLOCK_SIZE-1:0]                      in_ready,

    output logic [`GPU_ISSUE_CNT-1:0]                       slot_valid,
    output gpu_pkg::commit_full_t [`GPU_ISSUE_CNT-1:0]      slot_data,
    input  logic [`GPU_ISSUE_CNT-1:0]                       slot_ready
);

    localparam int BLOCK_BITS = `GPU_BLOCK_BITS;
    localparam int SLOT_BITS  = `GPU_SLOT_BITS;
    localparam int LANE_W     = $bits(gpu_pkg::commit_lane_t);

    logic [`GPU_BLOCK_SIZE-1:0][SLOT_BITS-1:0]      in_slot;
    logic [`GPU_ISSUE_CNT-1:0]                      buf_valid;
    gpu_pkg::commit_lane_t [`GPU_ISSUE_CNT-1:0]     buf_data;
    logic [`GPU_ISSUE_CNT-1:0]                      buf_ready;

    // Port i only carries warps whose low wid bits equal i, so the upper
    // slice bits of wid plus the port number pick a unique slot
    for (genvar i = 0; i < `GPU_BLOCK_SIZE; i++) begin : g_route
        assign in_slot[i] = {in_data[i].wid[BLOCK_BITS +: (SLOT_BITS - BLOCK_BITS)],
                             BLOCK_BITS'(i)};
        assign in_ready[i] = buf_ready[in_slot[i]];
    end

    always_comb begin
        buf_valid = '0;
        buf_data  = '0;
        for (int i = 0; i < `GPU_BLOCK_SIZE; i++) begin
            buf_valid[in_slot[i]] = in_valid[i];
            buf_data[in_slot[i]]  = in_data[i];
        end
    end

    for (genvar s = 0; s < `GPU_ISSUE_CNT; s++) begin : g_slot
        logic                  out_valid;
        gpu_pkg::commit_lane_t out_data;
        gpu_pkg::commit_full_t full;

        elastic_buffer #(
            .DATAW      (LANE_W)
        ) slot_buf (
            .clk        (clk),
            .rst        (rst),
            .valid_in   (buf_valid[s]),
            .data_in    (buf_data[s]),
            .ready_in   (buf_ready[s]),
            .valid_out  (out_valid),
            .data_out   (out_data),
            .ready_out  (slot_ready[s])
        );

        // Spread the lane slice over the thread range selected by pid
        always_comb begin
            full       = '0;
            full.uuid  = out_data.uuid;
            full.wid   = out_data.wid;
            full.pc    = out_data.pc;
            full.wb    = out_data.wb;
            full.rd    = out_data.rd;
            full.sop   = out_data.sop;
            full.eop   = out_data.eop;
            full.halt  = out_data.halt;
            for (int j = 0; j < `GPU_NUM_LANES; j++) begin
                full.tmask[int'(out_data.pid) * `GPU_NUM_LANES + j] = out_data.tmask[j];
                full.data[int'(out_data.pid) * `GPU_NUM_LANES + j]  = out_data.data[j];
            end
        end

        assign slot_valid[s] = out_valid;
        assign slot_data[s]  = full;
    end

endmodule

`default_nettype wire

// File: verilog/commit_writeback.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_cfg.svh"

module commit_writeback (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic                                        slot_valid,
    input  gpu_pkg::commit_full_t                       slot_data,
    output logic                                        slot_ready,

    output logic                                        retire_valid,
    output gpu_pkg::retire_t                            retire_data,
    input  logic                                        retire_ready,

    input  logic [`GPU_WID_BITS-`GPU_SLOT_BITS-1:0]     rd_wid_hi,
    input  logic [`GPU_NR_BITS-1:0]                     rd_reg,
    input  logic [$clog2(`GPU_NUM_THREADS)-1:0]         rd_thread,
    output logic [`GPU_XLEN-1:0]                        rd_data
);

    localparam int WHI_BITS       = `GPU_WID_BITS - `GPU_SLOT_BITS;
    localparam int WARPS_PER_SLOT = `GPU_NUM_WARPS / `GPU_ISSUE_CNT;
    localparam int NUM_REGS       = 2 ** `GPU_NR_BITS;

    // Registers of the warps owned by this slot, one word per thread
    logic [`GPU_XLEN-1:0] regfile [WARPS_PER_SLOT][NUM_REGS][`GPU_NUM_THREADS];

    // Threads seen so far for the instruction in flight on each warp
    logic [`GPU_NUM_THREADS-1:0] merge_mask [WARPS_PER_SLOT];

    logic                        accept;
    logic [WHI_BITS-1:0]         whi;
    logic [`GPU_NUM_THREADS-1:0] merged;

    // A pending retire only holds back the packet that would overwrite it
    assign slot_ready = !(slot_data.eop && retire_valid && !retire_ready);
    assign accept     = slot_valid && slot_ready;

    assign whi = slot_data.wid[`GPU_WID_BITS-1:`GPU_SLOT_BITS];

    // A sop packet starts a fresh mask, later packets add to it
    assign merged = (slot_data.sop ? '0 : merge_mask[whi]) | slot_data.tmask;

    always_ff @(posedge clk) begin
        if (accept && slot_data.wb) begin
            for (int t = 0; t < `GPU_NUM_THREADS; t++) begin
                if (slot_data.tmask[t]) begin
                    regfile[whi][slot_data.rd][t] <= slot_data.data[t];
                end
            end
        end
    end

    assign rd_data = regfile[rd_wid_hi][rd_reg][rd_thread];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WARPS_PER_SLOT; w++) begin
                merge_mask[w] <= '0;
            end
        end else if (accept) begin
            merge_mask[whi] <= slot_data.eop ? '0 : merged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else if (accept && slot_data.eop) begin
            retire_valid <= 1'b1;
        end else if (retire_ready) begin
            retire_valid <= 1'b0;
        end
    end

    // The record is only loaded on the last packet of an instruction
    always_ff @(posedge clk) begin
        if (accept && slot_data.eop) begin
            retire_data.uuid  <= slot_data.uuid;
            retire_data.wid   <= slot_data.wid;
            retire_data.pc    <= slot_data.pc;
            retire_data.halt  <= slot_data.halt;
            retire_data.tmask <= merged;
        end
    end

endmodule

`default_nettype wire

// File: verilog/commit_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_cfg.svh"

module commit_top (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic [`GPU_BLOCK_SIZE-1:0]                  in_valid,
    input  gpu_pkg::commit_lane_t [`GPU_BLOCK_SIZE-1:0] in_data,
    output logic [`GPU_BLOCK_SIZE-1:0]                  in_ready,

    output logic [`GPU_ISSUE_CNT-1:0]                   retire_valid,
    output gpu_pkg::retire_t [`GPU_ISSUE_CNT-1:0]       retire_data,
    input  logic [`GPU_ISSUE_CNT-1:0]                   retire_ready,

    input  logic [`GPU_SLOT_BITS-1:0]                   rd_slot,
    input  logic [`GPU_WID_BITS-`GPU_SLOT_BITS-1:0]     rd_wid_hi,
    input  logic [`GPU_NR_BITS-1:0]                     rd_reg,
    input  logic [$clog2(`GPU_NUM_THREADS)-1:0]         rd_thread,
    output logic [`GPU_XLEN-1:0]                        rd_data
);

    logic [`GPU_ISSUE_CNT-1:0]                      slot_valid;
    gpu_pkg::commit_full_t [`GPU_ISSUE_CNT-1:0]     slot_data;
    logic [`GPU_ISSUE_CNT-1:0]                      slot_ready;
    logic [`GPU_ISSUE_CNT-1:0][`GPU_XLEN-1:0]       slot_rd_data;

    commit_gather gather (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .slot_valid (slot_valid),
        .slot_data  (slot_data),
        .slot_ready (slot_ready)
    );

    for (genvar s = 0; s < `GPU_ISSUE_CNT; s++) begin : g_wb
        commit_writeback wb (
            .clk          (clk),
            .rst          (rst),
            .slot_valid   (slot_valid[s]),
            .slot_data    (slot_data[s]),
            .slot_ready   (slot_ready[s]),
            .retire_valid (retire_valid[s]),
            .retire_data  (retire_data[s]),
            .retire_ready (retire_ready[s]),
            .rd_wid_hi    (rd_wid_hi),
            .rd_reg       (rd_reg),
            .rd_thread    (rd_thread),
            .rd_data      (slot_rd_data[s])
        );
    end

    // Every slot sees the same read address, the owning slot is picked here
    assign rd_data = slot_rd_data[rd_slot];

endmodule

`default_nettype wire

// File: verif/commit_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_cfg.svh"

module commit_checker (
    input logic                                     clk,
    input logic                                     rst,
    input logic [`GPU_BLOCK_SIZE-1:0]               in_ready,
    input logic [`GPU_ISSUE_CNT-1:0]                retire_valid,
    input gpu_pkg::retire_t [`GPU_ISSUE_CNT-1:0]    retire_data,
    input logic [`GPU_ISSUE_CNT-1:0]                retire_ready
);

    // A stalled retire record has to stay put until the consumer takes it
    for (genvar s = 0; s < `GPU_ISSUE_CNT; s++) begin : g_slot
        retire_hold: assert property (
            @(posedge clk) disable iff (rst)
            retire_valid[s] && !retire_ready[s] |=> retire_valid[s] && $stable(retire_data[s])
        ) else $error("Retire record on slot %0d changed or dropped while stalled", s);
    end

    // Reset is synchronous, so the first edge with rst high clears valid
    // and every edge after that must see it low
    retire_in_reset: assert property (
        @(posedge clk) rst |=> retire_valid == '0
    ) else $error("retire_valid is high while reset is asserted");

    // Ready comes straight from the slot buffers and must never be X
    in_ready_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(in_ready)
    ) else $error("in_ready is unknown after reset");

endmodule

bind commit_top commit_checker checker0 (
    .clk          (clk),
    .rst          (rst),
    .in_ready     (in_ready),
    .retire_valid (retire_valid),
    .retire_data  (retire_data),
    .retire_ready (retire_ready)
);

`default_nettype wire

// File: verif/commit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_cfg.svh"

module commit_tb;

    localparam int NT          = `GPU_NUM_THREADS;
    localparam int NL          = `GPU_NUM_LANES;
    localparam int NW          = `GPU_NUM_WARPS;
    localparam int ISSUE       = `GPU_ISSUE_CNT;
    localparam int XLEN        = `GPU_XLEN;
    localparam int NR_BITS     = `GPU_NR_BITS;
    localparam int NUM_REGS    = 2 ** `GPU_NR_BITS;
    localparam int UUID_BITS   = `GPU_UUID_WIDTH;
    localparam int WID_BITS    = `GPU_WID_BITS;
    localparam int PID_BITS    = `GPU_PID_BITS;
    localparam int SLOT_BITS   = `GPU_SLOT_BITS;
    localparam int WHI_BITS    = `GPU_WID_BITS - `GPU_SLOT_BITS;
    localparam int TID_BITS    = $clog2(`GPU_NUM_THREADS);
    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;
    localparam int RAND_INSTRS = 40;

    logic                                        clk;
    logic                                        rst;
    logic [`GPU_BLOCK_SIZE-1:0]                  in_valid;
    gpu_pkg::commit_lane_t [`GPU_BLOCK_SIZE-1:0] in_data;
    logic [`GPU_BLOCK_SIZE-1:0]                  in_ready;
    logic [ISSUE-1:0]                            retire_valid;
    gpu_pkg::retire_t [ISSUE-1:0]                retire_data;
    logic [ISSUE-1:0]                            retire_ready = '1;
    logic [SLOT_BITS-1:0]                        rd_slot;
    logic [WHI_BITS-1:0]                         rd_wid_hi;
    logic [NR_BITS-1:0]                          rd_reg;
    logic [TID_BITS-1:0]                         rd_thread;
    logic [XLEN-1:0]                             rd_data;

    // Each port has its own source so the two traffic processes never drive the same signal
    logic                  valid_p0;
    logic                  valid_p1;
    gpu_pkg::commit_lane_t data_p0;
    gpu_pkg::commit_lane_t data_p1;

    assign in_valid = {valid_p1, valid_p0};
    assign in_data  = {data_p1, data_p0};

    // Reference model
    gpu_pkg::retire_t exp_q [ISSUE][$];
    logic [XLEN-1:0]  shadow [NW][NUM_REGS][NT];
    bit               known [NW][NUM_REGS][NT];
    integer           seed = 32'h6b38bc51;
    bit               ready_random = 1'b0;

    commit_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire_data  (retire_data),
        .retire_ready (retire_ready),
        .rd_slot      (rd_slot),
        .rd_wid_hi    (rd_wid_hi),
        .rd_reg       (rd_reg),
        .rd_thread    (rd_thread),
        .rd_data      (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic mismatch_exit(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // Lane j of part p lands on thread p * lanes + j
    function automatic logic [NT-1:0] expand_mask(input logic [NL-1:0] lanes,
                                                  input logic [PID_BITS-1:0] pid);
        return NT'(lanes) << (int'(pid) * NL);
    endfunction

    function automatic string record_text(input gpu_pkg::retire_t r);
        return $sformatf("uuid %h wid %0d pc %h halt %b mask %b",
                         r.uuid, r.wid, r.pc, r.halt, r.tmask);
    endfunction

    function automatic gpu_pkg::commit_lane_t make_pkt(
        input int uuid, input int wid, input logic [XLEN-1:0] pc, input bit wb,
        input int rd, input bit halt, input int pid, input logic [NL-1:0] tmask,
        input logic [XLEN-1:0] d0, input logic [XLEN-1:0] d1, input bit sop, input bit eop);
        gpu_pkg::commit_lane_t p;
        p         = '0;
        p.uuid    = UUID_BITS'(uuid);
        p.wid     = WID_BITS'(wid);
        p.tmask   = tmask;
        p.pc      = pc;
        p.wb      = wb;
        p.rd      = NR_BITS'(rd);
        p.data[0] = d0;
        p.data[1] = d1;
        p.pid     = PID_BITS'(pid);
        p.sop     = sop;
        p.eop     = eop;
        p.halt    = halt;
        return p;
    endfunction

    function automatic void update_shadow(input gpu_pkg::commit_lane_t pkt);
        int t;
        if (pkt.wb) begin
            for (int j = 0; j < NL; j++) begin
                if (pkt.tmask[j]) begin
                    t = int'(pkt.pid) * NL + j;
                    shadow[pkt.wid][pkt.rd][t] = pkt.data[j];
                    known[pkt.wid][pkt.rd][t]  = 1'b1;
                end
            end
        end
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int s = 0; s < ISSUE; s++) begin
            n += exp_q[s].size();
        end
        return n;
    endfunction

    task automatic send_packet(input int port, input gpu_pkg::commit_lane_t pkt);
        int waited;
        bit accepted;
        waited   = 0;
        accepted = 1'b0;
        @(posedge clk);
        if (port == 0) begin
            valid_p0 <= 1'b1;
            data_p0  <= pkt;
        end else begin
            valid_p1 <= 1'b1;
            data_p1  <= pkt;
        end
        // Ready is stable at the falling edge, the transfer is on the next rising one
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready[port];
            if (!accepted) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run($sformatf("port %0d did not accept a packet in time", port));
                end
            end
        end
        @(posedge clk);
        if (port == 0) begin
            valid_p0 <= 1'b0;
        end else begin
            valid_p1 <= 1'b0;
        end
        update_shadow(pkt);
    endtask

    // The expected record is queued before the first packet goes out
    task automatic send_instr(input int port, input gpu_pkg::commit_lane_t p0,
                              input gpu_pkg::commit_lane_t p1, input bit two);
        gpu_pkg::retire_t      rec;
        gpu_pkg::commit_lane_t last;
        last      = two ? p1 : p0;
        rec.uuid  = last.uuid;
        rec.wid   = last.wid;
        rec.pc    = last.pc;
        rec.halt  = last.halt;
        rec.tmask = expand_mask(p0.tmask, p0.pid);
        if (two) begin
            rec.tmask = rec.tmask | expand_mask(p1.tmask, p1.pid);
        end
        exp_q[int'(last.wid) % ISSUE].push_back(rec);
        send_packet(port, p0);
        if (two) begin
            send_packet(port, p1);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (outstanding() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                abort_run($sformatf("%0d instructions never retired", outstanding()));
            end
        end
    endtask

    task automatic check_reg(input int wid, input int r, input int t);
        @(posedge clk);
        rd_slot   <= SLOT_BITS'(wid % ISSUE);
        rd_wid_hi <= WHI_BITS'(wid / ISSUE);
        rd_reg    <= NR_BITS'(r);
        rd_thread <= TID_BITS'(t);
        @(negedge clk);
        assert (rd_data === shadow[wid][r][t])
            else mismatch_exit($sformatf("warp %0d r%0d thread %0d read %h, expected %h",
                                         wid, r, t, rd_data, shadow[wid][r][t]));
    endtask

    task automatic port_traffic(input int port, input int count);
        gpu_pkg::commit_lane_t p0;
        gpu_pkg::commit_lane_t p1;
        int  wid;
        int  rd;
        bit  two;
        bit  wb;
        bit  halt;
        logic [XLEN-1:0] pc;
        for (int n = 0; n < count; n++) begin
            wid  = 2 * ($random(seed) & 3) + port;
            rd   = $random(seed) & 7;
            two  = ($random(seed) & 1) != 0;
            wb   = ($random(seed) & 3) != 0;
            halt = ($random(seed) & 15) == 0;
            pc   = $random(seed);
            if (two) begin
                p0 = make_pkt(128 * port + n, wid, pc, wb, rd, halt, 0, NL'($random(seed)),
                              $random(seed), $random(seed), 1'b1, 1'b0);
                p1 = make_pkt(128 * port + n, wid, pc, wb, rd, halt, 1, NL'($random(seed)),
                              $random(seed), $random(seed), 1'b0, 1'b1);
            end else begin
                p0 = make_pkt(128 * port + n, wid, pc, wb, rd, halt, $random(seed) & 1,
                              NL'($random(seed)), $random(seed), $random(seed), 1'b1, 1'b1);
                p1 = p0;
            end
            send_instr(port, p0, p1, two);
        end
    endtask

    always @(posedge clk) begin
        if (ready_random) begin
            retire_ready <= ISSUE'($random(seed));
        end else begin
            retire_ready <= '1;
        end
    end

    // Retire monitor, compares each accepted record with the head of its slot queue
    always @(negedge clk) begin
        gpu_pkg::retire_t want;
        if (!rst) begin
            for (int s = 0; s < ISSUE; s++) begin
                if (retire_valid[s]) begin
                    assert (exp_q[s].size() != 0)
                        else abort_run($sformatf("slot %0d retired with nothing outstanding", s));
                    if (retire_ready[s] && exp_q[s].size() != 0) begin
                        want = exp_q[s].pop_front();
                        assert (retire_data[s] === want)
                            else mismatch_exit($sformatf("slot %0d got %s, want %s", s,
                                                         record_text(retire_data[s]),
                                                         record_text(want)));
                    end
                end
            end
        end
    end

    initial begin
        gpu_pkg::commit_lane_t pa;
        gpu_pkg::commit_lane_t pb;
        rst       = 1'b1;
        valid_p0  = 1'b0;
        valid_p1  = 1'b0;
        data_p0   = '0;
        data_p1   = '0;
        rd_slot   = '0;
        rd_wid_hi = '0;
        rd_reg    = '0;
        rd_thread = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Nothing may retire before any instruction is sent
        repeat (6) begin
            @(negedge clk);
            assert (retire_valid == '0)
                else mismatch_exit("retire_valid is high before any instruction was sent");
        end

        // Single-packet instructions, one per warp, each on the port of its low wid bit
        for (int w = 0; w < NW; w++) begin
            pa = make_pkt(8'h10 + w, w, 32'h1000 + w * 4, 1'b1, 1, w == 7, w % 2, 2'b11,
                          32'h100 + w, 32'h200 + w, 1'b1, 1'b1);
            send_instr(w % 2, pa, pa, 1'b0);
        end
        drain();
        for (int w = 0; w < NW; w++) begin
            for (int t = 0; t < NT; t++) begin
                if (known[w][1][t]) begin
                    check_reg(w, 1, t);
                end
            end
        end

        // Two packets fill all four threads of r7 on warp 5
        pa = make_pkt(8'h20, 5, 32'h2000, 1'b1, 7, 1'b0, 0, 2'b11, 32'ha0, 32'ha1, 1'b1, 1'b0);
        pb = make_pkt(8'h20, 5, 32'h2000, 1'b1, 7, 1'b0, 1, 2'b11, 32'ha2, 32'ha3, 1'b0, 1'b1);
        send_instr(1, pa, pb, 1'b1);
        drain();
        for (int t = 0; t < NT; t++) begin
            check_reg(5, 7, t);
        end

        // Part 1 with only lane 0 active touches thread 2 alone
        pa = make_pkt(8'h21, 5, 32'h2004, 1'b1, 7, 1'b0, 1, 2'b01, 32'hb2, 32'hb3, 1'b1, 1'b1);
        send_instr(1, pa, pa, 1'b0);
        drain();
        for (int t = 0; t < NT; t++) begin
            check_reg(5, 7, t);
        end

        // Without wb the register keeps its contents
        pa = make_pkt(8'h22, 5, 32'h2008, 1'b0, 7, 1'b0, 0, 2'b11, 32'hc0, 32'hc1, 1'b1, 1'b1);
        send_instr(1, pa, pa, 1'b0);
        drain();
        for (int t = 0; t < NT; t++) begin
            check_reg(5, 7, t);
        end

        // Partial masks from both parts merge into 0110
        pa = make_pkt(8'h23, 6, 32'h3000, 1'b1, 9, 1'b1, 0, 2'b10, 32'hd0, 32'hd1, 1'b1, 1'b0);
        pb = make_pkt(8'h23, 6, 32'h3000, 1'b1, 9, 1'b1, 1, 2'b01, 32'hd2, 32'hd3, 1'b0, 1'b1);
        send_instr(0, pa, pb, 1'b1);
        drain();
        check_reg(6, 9, 1);
        check_reg(6, 9, 2);

        // Random traffic on both ports with retire back-pressure
        ready_random = 1'b1;
        fork
            port_traffic(0, RAND_INSTRS);
            port_traffic(1, RAND_INSTRS);
        join
        ready_random = 1'b0;
        drain();
        for (int w = 0; w < NW; w++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                for (int t = 0; t < NT; t++) begin
                    if (known[w][r][t]) begin
                        check_reg(w, r, t);
                    end
                end
            end
        end

        repeat (4) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/gpu_pkg.sv
verilog/elastic_buffer.sv
verilog/commit_gather.sv
verilog/commit_writeback.sv
verilog/commit_top.sv
verif/commit_checker.sv
verif/commit_tb.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := commit_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := TB PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verilog/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
